//--- hdl/conv_layer_pkg.sv
package conv_layer_pkg;

  // array geometry
  localparam int lanes = 16;
  localparam int data_w = 16;
  localparam int acc_w = 40;

  // feature memory depth 64, weight table depth 16 taps
  localparam int addr_w = 6;
  localparam int waddr_w = 4;

  // number of convolution stages in the layer
  localparam int n_stages = 5;

  // largest positive value a result lane can hold
  localparam int lane_max = 2 ** (data_w - 1) - 1;

  // one feature word, lane 0 in the low bits
  typedef logic [lanes*data_w-1:0] word_t;

  // one tap row, weight of output lane o and input lane i at (o*lanes+i)
  typedef logic [lanes*lanes*data_w-1:0] weight_row_t;

  // one bias per output lane
  typedef logic [lanes*data_w-1:0] bias_vec_t;

  typedef enum logic [2:0] {
    stage_conv0 = 3'd0,
    stage_conv1 = 3'd1,
    stage_conv2 = 3'd2,
    stage_conv3 = 3'd3,
    stage_conv4 = 3'd4
  } stage_e;

  // fixed weight rule, range -4 to 4
  function automatic logic signed [data_w-1:0] weight_of(input stage_e stage,
                                                          input int tap,
                                                          input int out_lane,
                                                          input int in_lane);
    int sum;
    sum = 7 * int'(stage) + 3 * tap + 5 * out_lane + in_lane;
    return data_w'((sum % 9) - 4);
  endfunction

  // fixed bias rule
  function automatic logic signed [data_w-1:0] bias_of(input stage_e stage,
                                                        input int out_lane);
    int value;
    value = 16 * int'(stage) - out_lane;
    return data_w'(value);
  endfunction

  // odd stages take memory 2 as source and write memory 1
  function automatic logic stage_reads_mem2(input stage_e stage);
    return (int'(stage) % 2) == 1;
  endfunction

endpackage

//--- hdl/feature_ram.sv
module feature_ram
  import conv_layer_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [addr_w-1:0] addr,
  input  word_t             wdata,
  input  logic              we,
  output word_t             rdata
);

  localparam int depth = 2 ** addr_w;

  word_t mem [depth];

  // write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // registered read, old word on a read during write
  always_ff @(posedge clk) begin
    if (rst) begin
      rdata <= '0;
    end else begin
      rdata <= mem[addr];
    end
  end

endmodule

//--- hdl/coef_rom.sv
module coef_rom
  import conv_layer_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  stage_e             stage,
  input  logic [waddr_w-1:0] weight_addr,
  output weight_row_t        weights,
  output bias_vec_t          bias
);

  localparam int taps = 2 ** waddr_w;

  // one full tap row of the weight rule
  function automatic weight_row_t tap_row(input stage_e s, input int tap);
    weight_row_t row;
    row = '0;
    for (int o = 0; o < lanes; o++) begin
      for (int i = 0; i < lanes; i++) begin
        row[(o*lanes+i)*data_w +: data_w] = weight_of(s, tap, o, i);
      end
    end
    return row;
  endfunction

  // one table per convolution stage, constant after elaboration
  weight_row_t rom [n_stages][taps];

  for (genvar s = 0; s < n_stages; s++) begin : g_stage
    for (genvar t = 0; t < taps; t++) begin : g_tap
      assign rom[s][t] = tap_row(stage_e'(s), t);
    end
  end

  // stage code picks the table, tap address picks the row
  always_ff @(posedge clk) begin
    if (rst) begin
      weights <= '0;
    end else if (int'(stage) < n_stages) begin
      weights <= rom[stage][weight_addr];
    end else begin
      // unused stage codes give an all zero row
      weights <= '0;
    end
  end

  // bias set of the current stage
  always_comb begin
    for (int o = 0; o < lanes; o++) begin
      bias[o*data_w +: data_w] = bias_of(stage, o);
    end
  end

endmodule

//--- hdl/mac_array.sv
module mac_array
  import conv_layer_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  word_t       x,
  input  weight_row_t weights,
  input  bias_vec_t   bias,
  input  word_t       skip,
  input  stage_e      stage,
  input  logic        acc_clear,
  input  logic        acc_en,
  output word_t       result
);

  // one accumulator per output lane
  logic signed [acc_w-1:0] acc [lanes];

  // dot product of x with each weight row
  logic signed [acc_w-1:0] dot [lanes];

  always_comb begin
    logic signed [2*data_w-1:0] prod;
    prod = '0;
    for (int o = 0; o < lanes; o++) begin
      dot[o] = '0;
      for (int i = 0; i < lanes; i++) begin
        prod = $signed(x[i*data_w +: data_w])
             * $signed(weights[(o*lanes+i)*data_w +: data_w]);
        dot[o] = dot[o] + prod;
      end
    end
  end

  // bias preload has priority over accumulation
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int o = 0; o < lanes; o++) begin
        acc[o] <= '0;
      end
    end else if (acc_clear) begin
      for (int o = 0; o < lanes; o++) begin
        acc[o] <= $signed(bias[o*data_w +: data_w]);
      end
    end else if (acc_en) begin
      for (int o = 0; o < lanes; o++) begin
        acc[o] <= acc[o] + dot[o];
      end
    end
  end

  // skip add in the last stage, then relu and saturation
  always_comb begin
    logic signed [acc_w:0] skip_ext;
    logic signed [acc_w:0] total;
    skip_ext = '0;
    total = '0;
    for (int o = 0; o < lanes; o++) begin
      skip_ext = '0;
      if (stage == stage_conv4) begin
        skip_ext = $signed(skip[o*data_w +: data_w]);
      end
      // one extra bit so the skip add cannot wrap
      total = acc[o] + skip_ext;
      if (total < 0) begin
        result[o*data_w +: data_w] = '0;
      end else if (total > lane_max) begin
        result[o*data_w +: data_w] = data_w'(lane_max);
      end else begin
        result[o*data_w +: data_w] = total[data_w-1:0];
      end
    end
  end

endmodule

//--- hdl/conv_layer.sv
module conv_layer
  import conv_layer_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               xfer_wr,
  input  logic [addr_w-1:0]  xfer_addr,
  input  word_t              xfer_data,
  input  stage_e             stage,
  input  logic               load,
  input  logic               acc_clear,
  input  logic               acc_en,
  input  logic               padding,
  input  logic [addr_w-1:0]  mem1_addr,
  input  logic [addr_w-1:0]  mem2_addr,
  input  logic [addr_w-1:0]  skip_addr,
  input  logic [waddr_w-1:0] weight_addr,
  output word_t              mem2_data
);

  logic              odd_stage;
  logic [addr_w-1:0] mem1_addr_sel;
  logic [addr_w-1:0] skip_addr_sel;
  word_t             mem1_wdata;
  logic              mem1_we;
  logic              mem2_we;
  word_t             mem1_rdata;
  word_t             mem2_rdata;
  word_t             skip_rdata;
  word_t             src_word;
  word_t             x_word;
  weight_row_t       weights;
  bias_vec_t         bias;
  word_t             result;

  assign odd_stage = stage_reads_mem2(stage);

  // transfer port takes over memory 1 and the skip memory
  assign mem1_addr_sel = xfer_wr ? xfer_addr : mem1_addr;
  assign skip_addr_sel = xfer_wr ? xfer_addr : skip_addr;
  assign mem1_wdata    = xfer_wr ? xfer_data : result;

  // ping-pong write enables by stage parity
  assign mem1_we = xfer_wr | (load & odd_stage);
  assign mem2_we = load & ~odd_stage;

  // source memory, then zero padding
  assign src_word = odd_stage ? mem2_rdata : mem1_rdata;
  assign x_word   = padding ? '0 : src_word;

  feature_ram u_mem1 (
    .clk   (clk),
    .rst   (rst),
    .addr  (mem1_addr_sel),
    .wdata (mem1_wdata),
    .we    (mem1_we),
    .rdata (mem1_rdata)
  );

  feature_ram u_mem2 (
    .clk   (clk),
    .rst   (rst),
    .addr  (mem2_addr),
    .wdata (result),
    .we    (mem2_we),
    .rdata (mem2_rdata)
  );

  // skip memory only ever written by the transfer port
  feature_ram u_mem_skip (
    .clk   (clk),
    .rst   (rst),
    .addr  (skip_addr_sel),
    .wdata (mem1_wdata),
    .we    (xfer_wr),
    .rdata (skip_rdata)
  );

  coef_rom u_coef (
    .clk         (clk),
    .rst         (rst),
    .stage       (stage),
    .weight_addr (weight_addr),
    .weights     (weights),
    .bias        (bias)
  );

  mac_array u_mac (
    .clk       (clk),
    .rst       (rst),
    .x         (x_word),
    .weights   (weights),
    .bias      (bias),
    .skip      (skip_rdata),
    .stage     (stage),
    .acc_clear (acc_clear),
    .acc_en    (acc_en),
    .result    (result)
  );

  assign mem2_data = mem2_rdata;

endmodule

//--- test/conv_layer_assert.sv
module conv_layer_assert
  import conv_layer_pkg::*;
(
  input logic              clk,
  input logic              rst,
  input logic              xfer_wr,
  input logic              load,
  input logic              acc_clear,
  input logic              acc_en,
  input logic [addr_w-1:0] mem2_addr,
  input word_t             mem2_data,
  input stage_e            stage
);
  timeunit 1ns;
  timeprecision 100ps;

  // transfer port and layer writeback share memory 1
  a_xfer_load : assert property (@(posedge clk) disable iff (rst) !(xfer_wr && load))
    else $error("transfer write and load are high in the same cycle");

  // memory 2 word under a steady address only changes after a load in an even stage
  a_mem2_write : assert property (@(posedge clk) disable iff (rst)
    (!$past(rst) && mem2_addr == $past(mem2_addr) && !$past(load && !stage[0]))
    |=> (mem2_data === $past(mem2_data)))
    else $error("memory 2 changed without a load in an even stage");

  a_clear_en : assert property (@(posedge clk) disable iff (rst) !(acc_clear && acc_en))
    else $error("accumulator clear and enable are high in the same cycle");

endmodule

bind conv_layer conv_layer_assert u_conv_layer_assert (
  .clk       (clk),
  .rst       (rst),
  .xfer_wr   (xfer_wr),
  .load      (load),
  .acc_clear (acc_clear),
  .acc_en    (acc_en),
  .mem2_addr (mem2_addr),
  .mem2_data (mem2_data),
  .stage     (stage)
);

//--- test/conv_layer_tb.sv
module conv_layer_tb
  import conv_layer_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period = 40;
  localparam int reset_cycles = 5;
  localparam int depth = 2 ** addr_w;

  // cycle budget of reset, transfer, positions (n+3 each) and readbacks (count+1 each)
  localparam int total_cycles = reset_cycles + (depth + 1)
                              + 8 * 4 + 9 + 8 * 7 + 9 + 24 * 5 + 17
                              + 4 * 7 + 5 + 4 * 5 + 5 + 4 * 7 + 5 + 3;

  logic               clk;
  logic               rst;
  logic               xfer_wr;
  logic [addr_w-1:0]  xfer_addr;
  word_t              xfer_data;
  stage_e             stage;
  logic               load;
  logic               acc_clear;
  logic               acc_en;
  logic               padding;
  logic [addr_w-1:0]  mem1_addr;
  logic [addr_w-1:0]  mem2_addr;
  logic [addr_w-1:0]  skip_addr;
  logic [waddr_w-1:0] weight_addr;
  word_t              mem2_data;

  // model memories
  word_t mem1_m [depth];
  word_t mem2_m [depth];
  word_t skip_m [depth];

  // expected read-back words in issue order
  word_t exp_q [$];
  int    exp_addr_q [$];
  logic  rd_req;
  logic  rd_valid;

  conv_layer u_conv_layer (
    .clk         (clk),
    .rst         (rst),
    .xfer_wr     (xfer_wr),
    .xfer_addr   (xfer_addr),
    .xfer_data   (xfer_data),
    .stage       (stage),
    .load        (load),
    .acc_clear   (acc_clear),
    .acc_en      (acc_en),
    .padding     (padding),
    .mem1_addr   (mem1_addr),
    .mem2_addr   (mem2_addr),
    .skip_addr   (skip_addr),
    .weight_addr (weight_addr),
    .mem2_data   (mem2_data)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(clk_period / 2) clk = ~clk;
    end
  end

  initial begin
    #(2 * total_cycles * clk_period);
    $display("timeout: the tests did not finish within %0d cycles", 2 * total_cycles);
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

  task automatic check_value(input string name, input word_t got, input word_t expected);
    if (got !== expected) begin
      $display("[FAIL] %s: got %h expected %h", name, got, expected);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // weight and bias rules
  function automatic int rule_weight(input stage_e st, input int tap, input int o, input int i);
    return ((7 * int'(st) + 3 * tap + 5 * o + i) % 9) - 4;
  endfunction

  function automatic int rule_bias(input stage_e st, input int o);
    return 16 * int'(st) - o;
  endfunction

  function automatic int lane_value(input word_t w, input int i);
    return int'($signed(w[i*data_w +: data_w]));
  endfunction

  // one output word of a stage
  function automatic word_t conv_ref(input stage_e st, input int n, input int src[4],
                                     input int tap[4], input bit pad[4], input word_t skip_w);
    word_t  out;
    word_t  x;
    longint acc;
    out = '0;
    for (int o = 0; o < lanes; o++) begin
      acc = rule_bias(st, o);
      for (int k = 0; k < n; k++) begin
        if (!pad[k]) begin
          x = (int'(st) % 2 == 1) ? mem2_m[src[k]] : mem1_m[src[k]];
          for (int i = 0; i < lanes; i++) begin
            acc = acc + lane_value(x, i) * rule_weight(st, tap[k], o, i);
          end
        end
      end
      if (st == stage_conv4) begin
        acc = acc + lane_value(skip_w, o);
      end
      if (acc < 0) begin
        acc = 0;
      end else if (acc > 32767) begin
        acc = 32767;
      end
      out[o*data_w +: data_w] = 16'(acc);
    end
    return out;
  endfunction

  function automatic word_t small_word();
    word_t w;
    for (int i = 0; i < lanes; i++) begin
      w[i*data_w +: data_w] = 16'(int'($urandom_range(511)) - 256);
    end
    return w;
  endfunction

  task automatic transfer_all();
    word_t w;
    for (int a = 0; a < depth; a++) begin
      // top eight words hold extreme values for the saturation test
      if (a >= 60) begin
        w = {lanes{16'h8000}};
      end else if (a >= 56) begin
        w = {lanes{16'h7fff}};
      end else begin
        w = small_word();
      end
      @(posedge clk);
      xfer_wr   <= 1'b1;
      xfer_addr <= addr_w'(a);
      xfer_data <= w;
      mem1_m[a] = w;
      skip_m[a] = w;
    end
    @(posedge clk);
    xfer_wr <= 1'b0;
  endtask

  // clear, taps, skip address, load
  task automatic run_position(input stage_e st, input int n, input int src[4],
                              input int tap[4], input bit pad[4], input int skip_a,
                              input int out_a);
    word_t expected;
    bit    odd;
    expected = conv_ref(st, n, src, tap, pad, skip_m[skip_a]);
    odd = (int'(st) % 2 == 1);
    for (int c = 0; c <= n; c++) begin
      @(posedge clk);
      stage     <= st;
      acc_clear <= (c == 0);
      acc_en    <= (c != 0);
      padding   <= (c != 0) ? pad[c-1] : 1'b0;
      if (c < n) begin
        weight_addr <= waddr_w'(tap[c]);
        if (odd) begin
          mem2_addr <= addr_w'(src[c]);
        end else begin
          mem1_addr <= addr_w'(src[c]);
        end
      end else begin
        skip_addr <= addr_w'(skip_a);
      end
    end
    @(posedge clk);
    acc_en  <= 1'b0;
    padding <= 1'b0;
    load    <= 1'b1;
    if (odd) begin
      mem1_addr <= addr_w'(out_a);
      mem1_m[out_a] = expected;
    end else begin
      mem2_addr <= addr_w'(out_a);
      mem2_m[out_a] = expected;
    end
    @(posedge clk);
    load <= 1'b0;
  endtask

  task automatic readback_range(input int lo, input int count);
    for (int a = lo; a < lo + count; a++) begin
      @(posedge clk);
      mem2_addr <= addr_w'(a);
      rd_req    <= 1'b1;
      exp_q.push_back(mem2_m[a]);
      exp_addr_q.push_back(a);
    end
    @(posedge clk);
    rd_req <= 1'b0;
  endtask

  always @(posedge clk) begin
    rd_valid <= rd_req;
  end

  // read data is stable by the falling edge
  always @(negedge clk) begin
    if (rd_valid && exp_q.size() != 0) begin
      check_value($sformatf("mem2_data[%0d]", exp_addr_q.pop_front()), mem2_data,
                  exp_q.pop_front());
    end
  end

  initial begin
    int src [4];
    int tap [4];
    bit pad [4];
    int base;
    void'($urandom(62153));
    rst         = 1'b1;
    xfer_wr     = 1'b0;
    xfer_addr   = '0;
    xfer_data   = '0;
    stage       = stage_conv0;
    load        = 1'b0;
    acc_clear   = 1'b0;
    acc_en      = 1'b0;
    padding     = 1'b0;
    mem1_addr   = '0;
    mem2_addr   = '0;
    skip_addr   = '0;
    weight_addr = '0;
    rd_req      = 1'b0;
    pad = '{0, 0, 0, 0};
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;

    transfer_all();

    // single taps at random addresses
    for (int p = 0; p < 8; p++) begin
      src[0] = $urandom_range(55);
      tap[0] = $urandom_range(15);
      run_position(stage_conv0, 1, src, tap, pad, 0, p);
    end
    readback_range(0, 8);

    // four taps back to back
    for (int p = 0; p < 8; p++) begin
      base = $urandom_range(52);
      for (int k = 0; k < 4; k++) begin
        src[k] = base + k;
        tap[k] = (p * 4 + k) % 16;
      end
      run_position(stage_conv0, 4, src, tap, pad, 0, 8 + p);
    end
    readback_range(8, 8);

    // ping-pong chain from mem1 to mem2 to mem1 to mem2
    for (int p = 0; p < 8; p++) begin
      src = '{2 * p, 2 * p + 1, 0, 0};
      tap = '{0, 1, 0, 0};
      run_position(stage_conv0, 2, src, tap, pad, 0, 16 + p);
    end
    for (int p = 0; p < 8; p++) begin
      src = '{16 + p, 16 + (p + 1) % 8, 0, 0};
      tap = '{2, 3, 0, 0};
      run_position(stage_conv1, 2, src, tap, pad, 0, 48 + p);
    end
    for (int p = 0; p < 8; p++) begin
      src = '{48 + p, 48 + (p + 3) % 8, 0, 0};
      tap = '{4, 5, 0, 0};
      run_position(stage_conv2, 2, src, tap, pad, 0, 24 + p);
    end
    readback_range(16, 16);

    // partial and full padding
    src = '{4, 5, 6, 7};
    tap = '{0, 1, 2, 3};
    pad = '{0, 1, 0, 1};
    run_position(stage_conv0, 4, src, tap, pad, 0, 32);
    pad = '{1, 1, 1, 1};
    run_position(stage_conv0, 4, src, tap, pad, 0, 33);
    run_position(stage_conv2, 4, src, tap, pad, 0, 34);
    pad = '{1, 0, 0, 0};
    run_position(stage_conv2, 4, src, tap, pad, 0, 35);
    pad = '{0, 0, 0, 0};
    readback_range(32, 4);

    // skip add only in the last stage
    src = '{10, 11, 0, 0};
    tap = '{6, 7, 0, 0};
    run_position(stage_conv4, 2, src, tap, pad, 10, 36);
    src = '{20, 21, 0, 0};
    run_position(stage_conv4, 2, src, tap, pad, 20, 37);
    src = '{10, 11, 0, 0};
    run_position(stage_conv2, 2, src, tap, pad, 10, 38);
    src = '{20, 21, 0, 0};
    run_position(stage_conv2, 2, src, tap, pad, 20, 39);
    readback_range(36, 4);

    // extreme inputs drive lanes to 7fff and 0000
    tap = '{0, 1, 2, 3};
    src = '{56, 57, 58, 59};
    run_position(stage_conv0, 4, src, tap, pad, 0, 40);
    run_position(stage_conv2, 4, src, tap, pad, 0, 42);
    src = '{60, 61, 62, 63};
    run_position(stage_conv0, 4, src, tap, pad, 0, 41);
    run_position(stage_conv2, 4, src, tap, pad, 0, 43);
    readback_range(40, 4);

    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    @(posedge clk);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- sources.f
hdl/conv_layer_pkg.sv
hdl/feature_ram.sv
hdl/coef_rom.sv
hdl/mac_array.sv
hdl/conv_layer.sv
test/conv_layer_assert.sv
test/conv_layer_tb.sv

//--- Bender.yml
package:
  name: conv_layer

sources:
  - files:
      - hdl/conv_layer_pkg.sv
      - hdl/feature_ram.sv
      - hdl/coef_rom.sv
      - hdl/mac_array.sv
      - hdl/conv_layer.sv
  - target: test
    files:
      - test/conv_layer_assert.sv
      - test/conv_layer_tb.sv
